/* logic/beats_pkg.sv */
// ========================================
// Beat merger shared definitions
// Beat payload, channel id and arbiter
// state used across the merger datapath
// ========================================

package beats_pkg;

    // ========================================
    // Sizes
    // ========================================

    // Payload width of one beat, a single word
    localparam int beat_data_w = 32;

    // Channel count is fixed, the arbiter rotation assumes two
    localparam int n_chan = 2;

    // ========================================
    // Types
    // ========================================

    // One beat on any stream, payload plus end-of-packet flag
    typedef struct packed {
        logic [beat_data_w-1:0] data;
        logic                   last;
    } beat_t;

    // Channel number, one bit for two channels
    typedef logic chan_id_t;

    // Arbiter states
    // Idle picks a channel, locked holds it until the last beat
    typedef enum logic {
        arb_idle   = 1'b0,
        arb_locked = 1'b1
    } arb_state_e;

endpackage : beats_pkg

/* logic/beat_queue.sv */
// ========================================
// Beat queue
// Synchronous circular FIFO of beats with a
// write strobe, full and not-empty levels
// and a registered read port
// ========================================

`timescale 1ns/100ps

module beat_queue #(
    parameter int queue_depth = 8
) (
    input  logic            clk,
    input  logic            rst_n,

    // Write side, plain strobe
    input  logic            wr_en,
    input  beats_pkg::beat_t wr_beat,
    output logic            full,

    // Read side, data valid the cycle after rd_en
    output logic            not_empty,
    input  logic            rd_en,
    output beats_pkg::beat_t rd_beat
);

    import beats_pkg::*;

    // Address width, pointers carry one extra wrap bit
    localparam int aw = $clog2(queue_depth);

    beat_t       mem [queue_depth];
    logic [aw:0] wr_ptr;
    logic [aw:0] rd_ptr;
    logic        wr_fire;
    logic        rd_fire;

    // ========================================
    // Levels
    // ========================================

    // Same slot, opposite wrap bits means every slot is used
    assign full = (wr_ptr[aw] != rd_ptr[aw]) &&
                  (wr_ptr[aw-1:0] == rd_ptr[aw-1:0]);

    // Any pointer difference means at least one beat is stored
    assign not_empty = (wr_ptr != rd_ptr);

    // A write into a full queue is dropped
    assign wr_fire = wr_en && !full;

    // Reads on an empty queue are ignored
    assign rd_fire = rd_en && not_empty;

    // ========================================
    // Pointers
    // ========================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_fire) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_fire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // ========================================
    // Storage and registered read
    // ========================================

    // Storage and read register hold payload only
    always_ff @(posedge clk) begin
        if (wr_fire) begin
            mem[wr_ptr[aw-1:0]] <= wr_beat;
        end
        // Read data holds until the next read strobe
        if (rd_fire) begin
            rd_beat <= mem[rd_ptr[aw-1:0]];
        end
    end

endmodule : beat_queue

/* logic/skid_fifo.sv */
// ========================================
// Skid FIFO
// Small show-ahead FIFO with valid/ready
// on both sides and an occupancy count
// ========================================

`timescale 1ns/100ps

module skid_fifo #(
    parameter int skid_depth = 4
) (
    input  logic                            clk,
    input  logic                            rst_n,

    // Write side
    input  logic                            wr_valid,
    output logic                            wr_ready,
    input  beats_pkg::beat_t                wr_beat,

    // Read side, head entry shown while rd_valid is high
    output logic                            rd_valid,
    input  logic                            rd_ready,
    output beats_pkg::beat_t                rd_beat,

    // Stored entries, 0 to skid_depth
    output logic [$clog2(skid_depth+1)-1:0] count
);

    import beats_pkg::*;

    localparam int aw = (skid_depth > 1) ? $clog2(skid_depth) : 1;

    beat_t         mem [skid_depth];
    logic [aw-1:0] wr_ptr;
    logic [aw-1:0] rd_ptr;
    logic          wr_fire;
    logic          rd_fire;

    assign wr_ready = (count != skid_depth);
    assign rd_valid = (count != '0);
    assign rd_beat  = mem[rd_ptr];

    assign wr_fire = wr_valid && wr_ready;
    assign rd_fire = rd_valid && rd_ready;

    // Pointers wrap at skid_depth, which need not be a power of two
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_fire) begin
                wr_ptr <= (wr_ptr == aw'(skid_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_fire) begin
                rd_ptr <= (rd_ptr == aw'(skid_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous write and read leave the count unchanged
            if (wr_fire && !rd_fire) begin
                count <= count + 1'b1;
            end else if (rd_fire && !wr_fire) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            mem[wr_ptr] <= wr_beat;
        end
    end

endmodule : skid_fifo

/* logic/latency_bridge_beats.sv */
// ========================================
// Latency bridge for beats
// Turns a registered-read queue into a
// valid/ready stream through a skid FIFO
// ========================================

`timescale 1ns/100ps

module latency_bridge_beats #(
    parameter int skid_depth = 4
) (
    input  logic             clk,
    input  logic             rst_n,

    // Upstream queue, s_beat valid one cycle after s_valid && s_ready
    input  logic             s_valid,
    output logic             s_ready,
    input  beats_pkg::beat_t s_beat,

    // Downstream stream
    output logic             m_valid,
    input  logic             m_ready,
    output beats_pkg::beat_t m_beat
);

    localparam int cw = $clog2(skid_depth + 1);

    logic          drain_ip;
    logic          draining;
    logic          skid_wr_ready;
    logic [cw-1:0] skid_count;
    logic [cw:0]   pending;
    logic          room;

    // ========================================
    // Accept decision
    // ========================================

    // Consumer frees a skid slot this cycle
    assign draining = m_valid && m_ready;

    // The beat in flight has no slot in the count yet
    // so it is added until it lands in the skid FIFO
    assign pending = {1'b0, skid_count} + {{cw{1'b0}}, drain_ip};
    assign room    = (pending < (cw+1)'(skid_depth));

    // A drain in this cycle makes room for one more
    assign s_ready = room || draining;

    // ========================================
    // Beat in flight
    // ========================================

    // Set on the cycle a read is accepted, queue data arrives next cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            drain_ip <= 1'b0;
        end else begin
            drain_ip <= s_valid && s_ready;
        end
    end

    // ========================================
    // Skid FIFO
    // ========================================

    // Registered queue output is stable while drain_ip is high
    skid_fifo #(
        .skid_depth (skid_depth)
    ) u_skid (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_valid (drain_ip),
        .wr_ready (skid_wr_ready),
        .wr_beat  (s_beat),
        .rd_valid (m_valid),
        .rd_ready (m_ready),
        .rd_beat  (m_beat),
        .count    (skid_count)
    );

endmodule : latency_bridge_beats

/* logic/beat_arbiter.sv */
// ========================================
// Beat arbiter
// Packet-locked round-robin merge of two
// valid/ready beat streams onto one bus
// ========================================

`timescale 1ns/100ps

module beat_arbiter (
    input  logic                         clk,
    input  logic                         rst_n,

    // Bridge streams
    input  logic [beats_pkg::n_chan-1:0] in_valid,
    output logic [beats_pkg::n_chan-1:0] in_ready,
    input  beats_pkg::beat_t             in_beat0,
    input  beats_pkg::beat_t             in_beat1,

    // Merged output bus
    output logic                         out_valid,
    input  logic                         out_ready,
    output beats_pkg::beat_t             out_beat,
    output beats_pkg::chan_id_t          out_chan
);

    import beats_pkg::*;

    arb_state_e state;
    chan_id_t   grant;
    chan_id_t   pick;
    logic       xfer;

    // ========================================
    // Channel pick
    // ========================================

    // Both waiting, rotate away from the last grant
    // otherwise take whichever one is waiting
    always_comb begin
        if (in_valid[0] && in_valid[1]) begin
            pick = ~grant;
        end else if (in_valid[1]) begin
            pick = 1'b1;
        end else begin
            pick = 1'b0;
        end
    end

    assign xfer = out_valid && out_ready;

    // ========================================
    // Lock FSM
    // ========================================

    // grant doubles as the priority pointer, it holds through idle
    // Reset value of 1 lets channel 0 win the first tie
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= arb_idle;
            grant <= 1'b1;
        end else begin
            case (state)
                arb_idle: begin
                    if (|in_valid) begin
                        state <= arb_locked;
                        grant <= pick;
                    end
                end
                arb_locked: begin
                    // Release only after the packet's last beat goes out
                    if (xfer && out_beat.last) begin
                        state <= arb_idle;
                    end
                end
                default: begin
                    state <= arb_idle;
                end
            endcase
        end
    end

    // ========================================
    // Output mux
    // ========================================

    assign out_valid = (state == arb_locked) && in_valid[grant];
    assign out_beat  = grant ? in_beat1 : in_beat0;
    assign out_chan  = grant;

    // Only the granted channel sees the bus ready
    always_comb begin
        in_ready        = '0;
        in_ready[grant] = (state == arb_locked) && out_ready;
    end

endmodule : beat_arbiter

/* logic/beats_merge_top.sv */
// ========================================
// Two-channel beat merger
// Two queue-plus-bridge channels sharing
// one output bus through the arbiter
// ========================================

`timescale 1ns/100ps

module beats_merge_top #(
    parameter int queue_depth = 8,
    parameter int skid_depth  = 4
) (
    input  logic                         clk,
    input  logic                         rst_n,

    // Producer writes, plain strobes
    input  logic [beats_pkg::n_chan-1:0] wr_en,
    input  beats_pkg::beat_t             wr_beat0,
    input  beats_pkg::beat_t             wr_beat1,
    output logic [beats_pkg::n_chan-1:0] full,

    // Merged output
    output logic                         out_valid,
    input  logic                         out_ready,
    output beats_pkg::beat_t             out_beat,
    output beats_pkg::chan_id_t          out_chan
);

    import beats_pkg::*;

    // Queue to bridge, s_ready is the queue read strobe
    logic [n_chan-1:0] q_not_empty;
    logic [n_chan-1:0] q_rd_en;
    beat_t             q_beat0;
    beat_t             q_beat1;

    // Bridge to arbiter
    logic [n_chan-1:0] br_valid;
    logic [n_chan-1:0] br_ready;
    beat_t             br_beat0;
    beat_t             br_beat1;

    // ========================================
    // Channel 0
    // ========================================

    beat_queue #(.queue_depth(queue_depth)) u_queue0 (
        .clk(clk), .rst_n(rst_n),
        .wr_en(wr_en[0]), .wr_beat(wr_beat0), .full(full[0]),
        .not_empty(q_not_empty[0]), .rd_en(q_rd_en[0]), .rd_beat(q_beat0)
    );

    latency_bridge_beats #(.skid_depth(skid_depth)) u_bridge0 (
        .clk(clk), .rst_n(rst_n),
        .s_valid(q_not_empty[0]), .s_ready(q_rd_en[0]), .s_beat(q_beat0),
        .m_valid(br_valid[0]), .m_ready(br_ready[0]), .m_beat(br_beat0)
    );

    // ========================================
    // Channel 1
    // ========================================

    beat_queue #(.queue_depth(queue_depth)) u_queue1 (
        .clk(clk), .rst_n(rst_n),
        .wr_en(wr_en[1]), .wr_beat(wr_beat1), .full(full[1]),
        .not_empty(q_not_empty[1]), .rd_en(q_rd_en[1]), .rd_beat(q_beat1)
    );

    latency_bridge_beats #(.skid_depth(skid_depth)) u_bridge1 (
        .clk(clk), .rst_n(rst_n),
        .s_valid(q_not_empty[1]), .s_ready(q_rd_en[1]), .s_beat(q_beat1),
        .m_valid(br_valid[1]), .m_ready(br_ready[1]), .m_beat(br_beat1)
    );

    // ========================================
    // Arbiter
    // ========================================

    beat_arbiter u_arbiter (
        .clk(clk), .rst_n(rst_n),
        .in_valid(br_valid), .in_ready(br_ready),
        .in_beat0(br_beat0), .in_beat1(br_beat1),
        .out_valid(out_valid), .out_ready(out_ready),
        .out_beat(out_beat), .out_chan(out_chan)
    );

endmodule : beats_merge_top

/* bench/beats_merge_assertions.sv */
// ========================================
// Beat merger assertions
// Stream stability, grant lock and skid
// FIFO overflow on arbiter and bridges
// ========================================

`timescale 1ns/100ps

module beats_merge_assertions (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    out_valid,
    input logic                    out_ready,
    input beats_pkg::beat_t        out_beat,
    input beats_pkg::arb_state_e   state,
    input beats_pkg::chan_id_t     grant,
    input logic                    skid_wr,
    input logic                    skid_wr_ready
);

    import beats_pkg::*;

    // Stalled stream holds its beat
    assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> $stable(out_beat))
        else $error("Beat changed while the stream was stalled");

    // Locked arbiter keeps its channel until the packet's last beat transfers
    assert property (@(posedge clk) disable iff (!rst_n)
        state == arb_locked && out_valid && out_ready && !out_beat.last
        |=> state == arb_locked && $stable(grant))
        else $error("Arbiter left its channel in the middle of a packet");

    // Bridge never writes a full skid FIFO
    assert property (@(posedge clk) disable iff (!rst_n)
        skid_wr |-> skid_wr_ready)
        else $error("Skid FIFO written while full");

endmodule : beats_merge_assertions

bind beat_arbiter beats_merge_assertions u_arb_checks (
    .clk(clk), .rst_n(rst_n),
    .out_valid(out_valid), .out_ready(out_ready), .out_beat(out_beat),
    .state(state), .grant(grant),
    .skid_wr(1'b0), .skid_wr_ready(1'b1)
);

bind latency_bridge_beats beats_merge_assertions u_bridge_checks (
    .clk(clk), .rst_n(rst_n),
    .out_valid(m_valid), .out_ready(m_ready), .out_beat(m_beat),
    .state(beats_pkg::arb_idle), .grant(1'b0),
    .skid_wr(drain_ip), .skid_wr_ready(skid_wr_ready)
);

/* bench/beats_merge_tb.sv */
// ========================================
// Beat merger testbench
// Directed tests checked against per-channel
// reference queues on the merged output
// ========================================

`timescale 1ns/100ps

module beats_merge_tb;

    import beats_pkg::*;

    localparam int rand_cycles = 40;
    // Queue plus skid FIFO of one channel
    localparam int hold_beats  = 8 + 4;
    // Beats written by all tests set the watchdog length
    localparam int total_beats = 4 + 15 + 8 + 13 + 2 * rand_cycles + 2;

    logic       clk = 1'b0;
    logic       rst_n;
    logic [1:0] wr_en;
    beat_t      wr_beat0;
    beat_t      wr_beat1;
    logic [1:0] full;
    logic       out_valid;
    logic       out_ready;
    beat_t      out_beat;
    chan_id_t   out_chan;

    // Reference beats per channel and the channel of each packet seen
    beat_t    exp_q0[$];
    beat_t    exp_q1[$];
    chan_id_t pkt_log[$];
    logic     in_pkt = 1'b0;
    chan_id_t pkt_chan = 1'b0;
    int       cyc = 0;
    int       first_valid = -1;
    int       err_value = 0;
    int       err_other = 0;
    int       seed;
    string    test_name = "reset";

    beats_merge_top #(.queue_depth(8), .skid_depth(4)) dut (.*);

    always #20 clk = ~clk;

    // Edge counter for latency checks
    always @(posedge clk) cyc <= cyc + 1;

    function automatic beat_t make_beat(input logic [31:0] d, input logic l);
        beat_t b;
        b.data = d;
        b.last = l;
        return b;
    endfunction

    // ========================================
    // Compare tasks
    // ========================================

    task automatic check_beat(input string what, input beat_t exp, input beat_t act);
        if (exp !== act) begin
            err_value++;
            $display("ERR %s %s: expected %h/%b actual %h/%b", test_name, what,
                     exp.data, exp.last, act.data, act.last);
        end
    endtask

    task automatic check_chan(input string what, input chan_id_t exp, input chan_id_t act);
        if (exp !== act) begin
            err_value++;
            $display("ERR %s %s: expected %0d actual %0d", test_name, what, exp, act);
        end
    endtask

    task automatic check_count(input string what, input int exp, input int act);
        if (exp != act) begin
            err_value++;
            $display("ERR %s %s: expected %0d actual %0d", test_name, what, exp, act);
        end
    endtask

    // Pops the reference beat for the channel on the bus
    task automatic take_beat();
        beat_t exp;
        if (out_chan == 1'b0 && exp_q0.size() != 0)
            exp = exp_q0.pop_front();
        else if (out_chan == 1'b1 && exp_q1.size() != 0)
            exp = exp_q1.pop_front();
        else begin
            err_other++;
            $display("%s: beat on channel %0d that was never written", test_name, out_chan);
            return;
        end
        check_beat("beat", exp, out_beat);
    endtask

    // ========================================
    // Output monitor
    // ========================================

    // Sampled mid-cycle so a transfer seen here lands on the next rising edge
    always @(negedge clk) begin
        if (rst_n && out_valid && first_valid < 0)
            first_valid = cyc;
        if (rst_n && out_valid && out_ready) begin
            // A packet must not be split by another channel
            if (in_pkt)
                check_chan("packet lock", pkt_chan, out_chan);
            else begin
                pkt_log.push_back(out_chan);
                pkt_chan = out_chan;
            end
            in_pkt = !out_beat.last;
            take_beat();
        end
    end

    // ========================================
    // Drivers
    // ========================================

    // One write cycle held off while a requested channel is full
    task automatic push(input logic [1:0] en, input beat_t b0, input beat_t b1);
        while ((en & full) != 2'b00) begin
            @(posedge clk);
            #2;
        end
        wr_en    = en;
        wr_beat0 = b0;
        wr_beat1 = b1;
        if (en[0])
            exp_q0.push_back(b0);
        if (en[1])
            exp_q1.push_back(b1);
        @(posedge clk);
        #2;
        wr_en = 2'b00;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while ((exp_q0.size() != 0 || exp_q1.size() != 0) && n < 400) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (n >= 400) begin
            err_other++;
            $display("%s: output stopped with %0d and %0d beats still missing",
                     test_name, exp_q0.size(), exp_q1.size());
        end
    endtask

    // ========================================
    // Directed tests
    // ========================================

    task automatic test_single();
        int wr_cyc;
        test_name   = "single";
        out_ready   = 1'b1;
        first_valid = -1;
        // First beat is taken on the next edge
        wr_cyc = cyc + 1;
        for (int i = 0; i < 4; i++)
            push(2'b01, make_beat(32'h1000 + i, i == 3), '0);
        wait_drain();
        check_count("first valid latency", 3, first_valid - wr_cyc);
        check_chan("channel", 1'b0, pkt_log[pkt_log.size() - 1]);
    endtask

    // Three 3-beat packets on channel 0 against three 2-beat packets on channel 1
    task automatic test_lock();
        int base;
        test_name = "lock";
        base = pkt_log.size();
        for (int i = 0; i < 9; i++)
            push({i < 6, 1'b1}, make_beat(32'h2000 + i, i % 3 == 2),
                 make_beat(32'h2100 + i, i % 2 == 1));
        wait_drain();
        check_count("packets", 6, pkt_log.size() - base);
    endtask

    task automatic test_round_robin();
        int base;
        test_name = "round robin";
        base      = pkt_log.size();
        out_ready = 1'b0;
        for (int i = 0; i < 4; i++)
            push(2'b11, make_beat(32'h3000 + i, 1'b1), make_beat(32'h3100 + i, 1'b1));
        // Let both skid FIFOs fill before releasing the bus
        repeat (6) @(posedge clk);
        #2;
        out_ready = 1'b1;
        wait_drain();
        check_count("packets", 8, pkt_log.size() - base);
        for (int i = base + 1; i < pkt_log.size(); i++)
            check_chan("order", ~pkt_log[i - 1], pkt_log[i]);
    endtask

    task automatic test_backpressure();
        int n;
        test_name = "backpressure";
        out_ready = 1'b0;
        n = 0;
        while (!full[0] && n < 32) begin
            push(2'b01, make_beat(32'h4000 + n, n % 3 == 2), '0);
            n++;
        end
        check_count("beats held at full", hold_beats, n);
        out_ready = 1'b1;
        // One more beat once the full queue has room again
        push(2'b01, make_beat(32'h40ff, 1'b1), '0);
        wait_drain();
    endtask

    task automatic test_random();
        logic [31:0] r0;
        logic [31:0] r1;
        logic [31:0] rc;
        test_name = "random";
        for (int i = 0; i < rand_cycles; i++) begin
            r0 = $random(seed);
            r1 = $random(seed);
            rc = $random(seed);
            out_ready = rc[0];
            push(rc[2:1] & ~full, make_beat(r0, rc[4:3] == 2'b00),
                 make_beat(r1, rc[6:5] == 2'b00));
        end
        out_ready = 1'b1;
        push(2'b11, make_beat(32'h5000, 1'b1), make_beat(32'h5100, 1'b1));
        wait_drain();
    endtask

    // ========================================
    // Sequence and watchdog
    // ========================================

    initial begin
        seed      = 32'h47b2;
        rst_n     = 1'b0;
        wr_en     = 2'b00;
        wr_beat0  = '0;
        wr_beat1  = '0;
        out_ready = 1'b0;
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
        test_single();
        test_lock();
        test_round_robin();
        test_backpressure();
        test_random();
        $display("Errors: %0d wrong values, %0d other failures", err_value, err_other);
        if (err_value + err_other == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

    initial begin
        repeat (total_beats * 20) @(posedge clk);
        $display("Watchdog expired before the tests finished");
        $display("TEST FAILED");
        $finish;
    end

endmodule : beats_merge_tb

/* verilog.f */
logic/beats_pkg.sv
logic/beat_queue.sv
logic/skid_fifo.sv
logic/latency_bridge_beats.sv
logic/beat_arbiter.sv
logic/beats_merge_top.sv
bench/beats_merge_assertions.sv
bench/beats_merge_tb.sv

/* Makefile */
# Verilator build and run of the beat merger testbench

SRCS := $(wildcard logic/*.sv bench/*.sv)

all: run

obj_dir/Vbeats_merge_tb: verilog.f $(SRCS)
	verilator --binary --timing --assert -f verilog.f --top-module beats_merge_tb

run: obj_dir/Vbeats_merge_tb
	./obj_dir/Vbeats_merge_tb > sim.log 2>&1 || true
	cat sim.log
	! grep -q "TEST FAILED" sim.log
	grep -q "TEST OK" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
